//--- design/icache_age_table.sv
// per-set age counters and victim way choice
`include "icache_config.svh"

module icache_age_table (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [`ICACHE_INDEX_W-1:0] index_i,
    input  icache_pkg::lookup_t        lookup_i,
    input  logic [`ICACHE_WAYS-1:0]    way_valid_i,
    input  logic                       fill_i,
    input  logic                       deliver_i,
    output logic                       victim_o
);

    logic [`ICACHE_AGE_W-1:0] age_q [`ICACHE_SETS][`ICACHE_WAYS];

    // empty way first, else the older one, way 0 on a tie
    always_comb begin
        if (!way_valid_i[0]) begin
            victim_o = 1'b0;
        end else if (!way_valid_i[1]) begin
            victim_o = 1'b1;
        end else begin
            victim_o = (age_q[index_i][1] > age_q[index_i][0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (deliver_i) begin
            // every other counter ages on each delivery
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (lookup_i.hit && s == index_i && w == lookup_i.way) begin
                        age_q[s][w] <= '0;
                    end else if (age_q[s][w] != `ICACHE_AGE_MAX) begin
                        age_q[s][w] <= age_q[s][w] + 1'b1;
                    end
                end
            end
        end else if (fill_i) begin
            age_q[index_i][victim_o] <= '0;   // fresh line
        end
    end

endmodule

//--- design/icache_config.svh
// cache geometry, field widths, way count and age limit
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch side
`define ICACHE_ADDR_W   32
`define ICACHE_INST_W   32

// address split, tag 31:9, index 8:3
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6

// organisation
`define ICACHE_SETS     64
`define ICACHE_WAYS     2
`define ICACHE_LINE_W   64   // one doubleword per way and set

// replacement
`define ICACHE_AGE_W    3
`define ICACHE_AGE_MAX  7

`endif

//--- design/icache_ctrl.sv
// instruction cache controller FSM for lookup, delivery and refill
module icache_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_ready_i,
    input  icache_pkg::lookup_t lookup_i,
    input  logic                mem_valid_i,
    output logic                inst_valid_o,
    output logic                lookup_en_o,
    output logic                fill_o,
    output logic                mem_req_en_o
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (inst_ready_i) begin
                    state_d = icache_pkg::LOOKUP;   // request accepted
                end
            end
            icache_pkg::LOOKUP: begin
                state_d = icache_pkg::COMPARE;
            end
            icache_pkg::COMPARE: begin
                if (lookup_i.hit) begin
                    state_d = icache_pkg::IDLE;
                end else begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                // line lands in the victim way, then look it up again
                if (mem_valid_i) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    assign lookup_en_o  = (state_q == icache_pkg::LOOKUP);
    assign inst_valid_o = (state_q == icache_pkg::COMPARE) && lookup_i.hit;
    assign mem_req_en_o = (state_q == icache_pkg::REFILL);
    assign fill_o       = mem_req_en_o && mem_valid_i;   // one cycle, on the response

endmodule

//--- design/icache_data_array.sv
// two-way doubleword store with instruction half select
`include "icache_config.svh"

module icache_data_array (
    input  logic                       clk,
    input  icache_pkg::fetch_addr_t    addr_i,
    input  logic                       lookup_en_i,
    input  logic                       fill_i,
    input  logic                       victim_i,
    input  logic [`ICACHE_LINE_W-1:0]  fill_data_i,
    input  icache_pkg::lookup_t        lookup_i,
    output logic [`ICACHE_INST_W-1:0]  inst_data_o
);

    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] rd_line_q [`ICACHE_WAYS];
    logic [`ICACHE_LINE_W-1:0] hit_line;

    always_ff @(posedge clk) begin
        if (fill_i) begin
            line_mem[victim_i][addr_i.index] <= fill_data_i;
        end
        if (lookup_en_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_line_q[w] <= line_mem[w][addr_i.index];
            end
        end
    end

    assign hit_line = rd_line_q[lookup_i.way];

    always_comb begin
        if (!lookup_i.hit) begin
            inst_data_o = '0;
        end else if (addr_i.half) begin
            inst_data_o = hit_line[`ICACHE_LINE_W-1:`ICACHE_INST_W];   // addr bit 2 set
        end else begin
            inst_data_o = hit_line[`ICACHE_INST_W-1:0];
        end
    end

endmodule

//--- design/icache_pkg.sv
// controller state enum, fetch address fields and lookup result struct
`include "icache_config.svh"

package icache_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,   // both stores read the set
        COMPARE = 2'd2,   // tag compare, hit delivery
        REFILL  = 2'd3
    } ctrl_state_e;

    // fetch address as seen by the arrays
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic                       half;     // upper or lower instruction
        logic [1:0]                 offset;
    } fetch_addr_t;

    typedef struct packed {
        logic hit;
        logic way;
    } lookup_t;

endpackage

//--- design/icache_tag_array.sv
// two-way tag store with valid bits, hit compare and fence sweep
`include "icache_config.svh"

module icache_tag_array (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  icache_pkg::fetch_addr_t addr_i,
    input  logic                    lookup_en_i,
    input  logic                    fill_i,
    input  logic                    fence_i,
    input  logic                    victim_i,
    output icache_pkg::lookup_t     lookup_o,
    output logic [`ICACHE_WAYS-1:0] way_valid_o
);

    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0]  valid_q [`ICACHE_SETS];
    logic [`ICACHE_TAG_W-1:0] rd_tag_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]  rd_valid_q;
    logic [`ICACHE_WAYS-1:0]  hit_way;
    logic [`ICACHE_INDEX_W:0] fence_cnt_q;   // one extra bit to saturate at 64
    logic                     fence_active;

    assign fence_active = fence_i && (fence_cnt_q < `ICACHE_SETS);

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[victim_i][addr_i.index] <= addr_i.tag;
        end
        if (lookup_en_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_tag_q[w] <= tag_mem[w][addr_i.index];
            end
        end
    end

    // sweep pointer, set n in the n-th fence cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fence_cnt_q <= '0;
        end else if (!fence_i) begin
            fence_cnt_q <= '0;
        end else if (fence_active) begin
            fence_cnt_q <= fence_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
            rd_valid_q <= '0;
        end else begin
            if (fence_active) begin
                valid_q[fence_cnt_q[`ICACHE_INDEX_W-1:0]] <= '0;
            end else if (fill_i) begin
                valid_q[addr_i.index][victim_i] <= 1'b1;
            end
            if (lookup_en_i) begin
                rd_valid_q <= valid_q[addr_i.index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = rd_valid_q[w] && (rd_tag_q[w] == addr_i.tag);
        end
    end

    assign lookup_o.hit = |hit_way;
    assign lookup_o.way = hit_way[1];   // both ways never hold the same tag
    assign way_valid_o  = rd_valid_q;

endmodule

//--- design/icache_top.sv
// instruction cache top with controller, tag, data and age blocks
`include "icache_config.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [`ICACHE_ADDR_W-1:0]  inst_addr_i,
    input  logic                       inst_ready_i,
    input  logic                       fence_i,
    input  mem_bus_pkg::mem_rsp_t      mem_rsp_i,
    output logic [`ICACHE_INST_W-1:0]  inst_data_o,
    output logic                       inst_valid_o,
    output mem_bus_pkg::mem_req_t      mem_req_o
);

    icache_pkg::fetch_addr_t fetch_addr;
    icache_pkg::lookup_t     lookup;
    logic                    lookup_en;
    logic                    fill;
    logic                    deliver;
    logic                    mem_req_en;
    logic                    victim;
    logic [`ICACHE_WAYS-1:0] way_valid;

    assign fetch_addr     = inst_addr_i;
    assign inst_valid_o   = deliver;
    assign mem_req_o.en   = mem_req_en;
    assign mem_req_o.addr = {inst_addr_i[`ICACHE_ADDR_W-1:3], 3'b000};   // whole doubleword

    icache_ctrl icache_ctrl_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_ready_i (inst_ready_i),
        .lookup_i     (lookup),
        .mem_valid_i  (mem_rsp_i.valid),
        .inst_valid_o (deliver),
        .lookup_en_o  (lookup_en),
        .fill_o       (fill),
        .mem_req_en_o (mem_req_en)
    );

    icache_tag_array icache_tag_array_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .addr_i      (fetch_addr),
        .lookup_en_i (lookup_en),
        .fill_i      (fill),
        .fence_i     (fence_i),
        .victim_i    (victim),
        .lookup_o    (lookup),
        .way_valid_o (way_valid)
    );

    icache_data_array icache_data_array_i (
        .clk         (clk),
        .addr_i      (fetch_addr),
        .lookup_en_i (lookup_en),
        .fill_i      (fill),
        .victim_i    (victim),
        .fill_data_i (mem_rsp_i.data),
        .lookup_i    (lookup),
        .inst_data_o (inst_data_o)
    );

    icache_age_table icache_age_table_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .index_i     (fetch_addr.index),
        .lookup_i    (lookup),
        .way_valid_i (way_valid),
        .fill_i      (fill),
        .deliver_i   (deliver),
        .victim_o    (victim)
    );

endmodule

//--- design/mem_bus_pkg.sv
// memory port request and response structs
`include "icache_config.svh"

package mem_bus_pkg;

    typedef struct packed {
        logic                      en;     // held until the response
        logic [`ICACHE_ADDR_W-1:0] addr;   // doubleword aligned
    } mem_req_t;

    typedef struct packed {
        logic                      valid;  // one-cycle pulse
        logic [`ICACHE_LINE_W-1:0] data;
    } mem_rsp_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module icache_tb \
    -o icache_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/icache_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test completed successfully" "$SIM_LOG"; then
    exit 0
fi
exit 1

//--- sim/icache_tb.sv
// testbench for the instruction cache with memory model, reference model and checks
`include "icache_config.svh"

module icache_tb;

    localparam int FETCH_TIMEOUT  = 60;
    localparam int FENCE_CYCLES   = 66;   // a little past the 64-set sweep
    localparam int RANDOM_FETCHES = 60;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [`ICACHE_ADDR_W-1:0] inst_addr;
    logic                      inst_ready;
    logic                      fence;
    mem_bus_pkg::mem_rsp_t     mem_rsp;
    logic [`ICACHE_INST_W-1:0] inst_data;
    logic                      inst_valid;
    mem_bus_pkg::mem_req_t     mem_req;

    // reference cache state
    logic [`ICACHE_TAG_W-1:0] ref_tag   [`ICACHE_WAYS][`ICACHE_SETS];
    logic                     ref_valid [`ICACHE_WAYS][`ICACHE_SETS];
    int                       ref_age   [`ICACHE_WAYS][`ICACHE_SETS];

    logic                      exp_miss = 1'b0;
    logic [`ICACHE_INST_W-1:0] exp_word = '0;
    logic [7:0]                accept_age;   // edges since the request was raised
    logic                      saw_req;
    int                        check_errors = 0;
    int                        timeout_errors = 0;

    icache_top icache_top_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_addr_i  (inst_addr),
        .inst_ready_i (inst_ready),
        .fence_i      (fence),
        .mem_rsp_i    (mem_rsp),
        .inst_data_o  (inst_data),
        .inst_valid_o (inst_valid),
        .mem_req_o    (mem_req)
    );

    always #50 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_age <= '0;
            saw_req    <= 1'b0;
        end else if (!inst_ready) begin
            accept_age <= '0;
            saw_req    <= 1'b0;
        end else begin
            if (accept_age != 8'hff) begin
                accept_age <= accept_age + 8'd1;
            end
            if (mem_req.en) begin
                saw_req <= 1'b1;
            end
        end
    end

    idle_valid: assert property (@(posedge clk) !inst_ready |-> !inst_valid)
        else report_mismatch("inst_valid_o", 32'($sampled(inst_valid)), 32'd0);
    idle_req: assert property (@(posedge clk) !inst_ready |-> !mem_req.en)
        else report_mismatch("mem_req_o.en", 32'($sampled(mem_req.en)), 32'd0);
    req_addr: assert property (@(posedge clk)
        mem_req.en |-> mem_req.addr == (inst_addr & ~32'h7))
        else report_mismatch("mem_req_o.addr", $sampled(mem_req.addr),
                             $sampled(inst_addr) & ~32'h7);
    miss_seen: assert property (@(posedge clk) inst_valid |-> saw_req == exp_miss)
        else report_mismatch("mem_req_o.en seen", 32'($sampled(saw_req)), 32'($sampled(exp_miss)));
    word_check: assert property (@(posedge clk) inst_valid |-> inst_data == exp_word)
        else report_mismatch("inst_data_o", $sampled(inst_data), $sampled(exp_word));
    hit_latency: assert property (@(posedge clk) inst_valid && !exp_miss |-> accept_age == 8'd2)
        else report_mismatch("hit latency", 32'($sampled(accept_age)), 32'd2);

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        check_errors++;
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, expected);
    endtask

    // both memory halves depend on the whole doubleword address
    function automatic logic [`ICACHE_LINE_W-1:0] line_data(input logic [`ICACHE_ADDR_W-1:0] a);
        logic [`ICACHE_ADDR_W-1:0] dw;
        dw = {a[`ICACHE_ADDR_W-1:3], 3'b000};
        return {dw ^ 32'h5a5a_a5a5, {dw[15:0], dw[31:16]} + 32'h1357_9bdf};
    endfunction

    function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input int tag, input int idx,
                                                            input int half);
        return {tag[`ICACHE_TAG_W-1:0], idx[`ICACHE_INDEX_W-1:0], half[0], 2'b00};
    endfunction

    function automatic int find_way(input logic [`ICACHE_ADDR_W-1:0] a);
        icache_pkg::fetch_addr_t fa;
        fa = a;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[w][fa.index] && ref_tag[w][fa.index] == fa.tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // empty way first, then the older way, way 0 on a tie
    function automatic int pick_victim(input logic [`ICACHE_INDEX_W-1:0] idx);
        if (!ref_valid[0][idx]) begin
            return 0;
        end
        if (!ref_valid[1][idx]) begin
            return 1;
        end
        return (ref_age[1][idx] > ref_age[0][idx]) ? 1 : 0;
    endfunction

    task automatic retire_fetch(input logic [`ICACHE_ADDR_W-1:0] a);
        icache_pkg::fetch_addr_t fa;
        int                      way;
        fa = a;
        way = find_way(a);
        if (way < 0) begin
            way = pick_victim(fa.index);
            ref_valid[way][fa.index] = 1'b1;
            ref_tag[way][fa.index]   = fa.tag;
        end
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (s == int'(fa.index) && w == way) begin
                    ref_age[w][s] = 0;
                end else if (ref_age[w][s] < `ICACHE_AGE_MAX) begin
                    ref_age[w][s]++;
                end
            end
        end
    endtask

    task automatic fetch(input logic [`ICACHE_ADDR_W-1:0] a);
        logic [`ICACHE_LINE_W-1:0] dword;
        int                        cycles;
        if (timeout_errors != 0) begin
            return;   // no more requests once the cache has hung
        end
        dword      = line_data(a);
        exp_miss   = (find_way(a) < 0);
        exp_word   = a[2] ? dword[`ICACHE_LINE_W-1:`ICACHE_INST_W] : dword[`ICACHE_INST_W-1:0];
        inst_addr  = a;
        inst_ready = 1'b1;
        cycles     = 0;
        while (!inst_valid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > FETCH_TIMEOUT) begin
                timeout_errors++;
                $display("no inst_valid_o within %0d cycles for address %h", FETCH_TIMEOUT, a);
                inst_ready = 1'b0;
                return;
            end
        end
        @(posedge clk);
        #1;
        inst_ready = 1'b0;
        retire_fetch(a);
        @(posedge clk);   // one idle edge between requests
        #1;
    endtask

    task automatic run_fence();
        fence = 1'b1;
        repeat (FENCE_CYCLES) begin
            @(posedge clk);
            #1;
        end
        fence = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // memory answers after 1 to 5 cycles
    initial begin : mem_model
        int delay;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.en) begin
                delay = $urandom_range(5, 1);
                repeat (delay) begin
                    @(posedge clk);
                end
                #1;
                mem_rsp.data  = line_data(mem_req.addr);
                mem_rsp.valid = 1'b1;
                @(posedge clk);
                #1;
                mem_rsp.valid = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(82));
        rst_n      = 1'b0;
        inst_addr  = '0;
        inst_ready = 1'b0;
        fence      = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_age[w][s]   = 0;
            end
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        fetch(32'h0000_1230);   // cold miss, lower half
        fetch(32'h0000_1234);   // upper half of the same line

        // three tags competing for set 5
        fetch(make_addr(1, 5, 0));
        fetch(make_addr(2, 5, 1));
        fetch(make_addr(1, 5, 1));
        fetch(make_addr(2, 5, 0));
        fetch(make_addr(1, 5, 0));
        fetch(make_addr(3, 5, 0));
        fetch(make_addr(1, 5, 1));
        fetch(make_addr(2, 5, 1));

        run_fence();
        fetch(32'h0000_1230);

        repeat (RANDOM_FETCHES) begin
            fetch(make_addr($urandom_range(3, 0), $urandom_range(7, 0), $urandom_range(1, 0)));
        end
        finish_run();
    end

endmodule

//--- verilog.f
+incdir+design
design/icache_pkg.sv
design/mem_bus_pkg.sv
design/icache_ctrl.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_age_table.sv
design/icache_top.sv
sim/icache_tb.sv
